//--- files.f
logic/mem_pkg.sv
logic/req_hold.sv
logic/word_lane.sv
logic/burst_adaptor.sv
logic/mem_ctrl.sv
logic/mem_hier.sv
test/burst_mem_model.sv
test/mem_hier_assert.sv
test/mem_hier_tb.sv

//--- logic/burst_adaptor.sv
`timescale 1ns/10ps
`default_nettype none

module burst_adaptor (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               line_read_i,
    input  wire logic               line_write_i,
    input  wire logic        [31:0] addr_i,
    input  wire mem_pkg::line_t     line_i,
    output mem_pkg::line_t          line_o,
    output logic                    line_done_o,
    output mem_pkg::bmem_out_t      bmem_o,
    input  wire mem_pkg::bmem_in_t  bmem_i
);

    import mem_pkg::*;

    logic [CNT_BITS-1:0]            cnt_q;     // beat counter
    logic [LINE_BITS-BEAT_BITS-1:0] shift_q;   // first three read beats
    logic                           active;
    logic                           last_beat;

    assign active    = line_read_i || line_write_i;
    assign last_beat = cnt_q == CNT_BITS'(BEATS - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_q <= '0;
        end else if (active && bmem_i.resp) begin
            cnt_q <= cnt_q + 1'b1;   // wraps to 0 after the last beat
        end
    end

    // lowest beat enters at the top and shifts down
    always_ff @(posedge clk) begin
        if (line_read_i && bmem_i.resp) begin
            shift_q <= {bmem_i.rdata, shift_q[LINE_BITS-BEAT_BITS-1:BEAT_BITS]};
        end
    end

    // full line is valid in the cycle of the last beat
    assign line_o      = {bmem_i.rdata, shift_q};
    assign line_done_o = active && bmem_i.resp && last_beat;

    always_comb begin
        bmem_o.addr  = addr_i;
        bmem_o.read  = line_read_i;
        bmem_o.write = line_write_i;
        bmem_o.wdata = line_i[cnt_q*BEAT_BITS +: BEAT_BITS];   // current write beat
    end

endmodule : burst_adaptor

`default_nettype wire

//--- logic/mem_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module mem_ctrl (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic imem_pending_i,
    input  wire logic dmem_pending_i,
    input  wire logic dmem_write_i,
    input  wire logic line_done_i,
    output logic      line_read_o,
    output logic      line_write_o,
    output logic      sel_dmem_o,
    output logic      imem_done_o,
    output logic      dmem_done_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_WRITE,
        ST_RESP
    } state_t;

    state_t state_q;
    state_t state_d;
    logic   sel_dmem_q;
    logic   sel_dmem_d;

    always_comb begin
        state_d    = state_q;
        sel_dmem_d = sel_dmem_q;
        case (state_q)
            ST_IDLE: begin
                if (dmem_pending_i) begin        // data port wins
                    sel_dmem_d = 1'b1;
                    state_d    = ST_READ;
                end else if (imem_pending_i) begin
                    sel_dmem_d = 1'b0;
                    state_d    = ST_READ;
                end
            end
            ST_READ: begin
                if (line_done_i) begin
                    // stores write the merged line back
                    if (sel_dmem_q && dmem_write_i) begin
                        state_d = ST_WRITE;
                    end else begin
                        state_d = ST_RESP;
                    end
                end
            end
            ST_WRITE: begin
                if (line_done_i) begin
                    state_d = ST_RESP;
                end
            end
            ST_RESP: begin
                state_d = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= ST_IDLE;
            sel_dmem_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            sel_dmem_q <= sel_dmem_d;
        end
    end

    assign line_read_o  = state_q == ST_READ;
    assign line_write_o = state_q == ST_WRITE;
    assign sel_dmem_o   = sel_dmem_q;
    assign imem_done_o  = (state_q == ST_RESP) && !sel_dmem_q;   // one cycle pulse
    assign dmem_done_o  = (state_q == ST_RESP) && sel_dmem_q;

endmodule : mem_ctrl

`default_nettype wire

//--- logic/mem_hier.sv
`timescale 1ns/10ps
`default_nettype none

module mem_hier (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               imem_read_i,
    input  wire mem_pkg::imem_req_t imem_req_i,
    output logic             [31:0] imem_rdata_o,
    output logic                    imem_resp_o,
    input  wire logic               dmem_read_i,
    input  wire logic               dmem_write_i,
    input  wire mem_pkg::dmem_req_t dmem_req_i,
    output logic             [31:0] dmem_rdata_o,
    output logic                    dmem_resp_o,
    output mem_pkg::bmem_out_t      bmem_o,
    input  wire mem_pkg::bmem_in_t  bmem_i
);

    import mem_pkg::*;

    imem_req_t   imem_held;
    dmem_req_t   dmem_in;
    dmem_req_t   dmem_held;
    logic        imem_pending;
    logic        dmem_pending;
    logic        imem_done;
    logic        dmem_done;
    logic        line_read;
    logic        line_write;
    logic        line_done;
    logic        sel_dmem;
    logic [31:0] line_addr;
    line_t       rd_line;
    line_t       line_q;     // last line read from memory
    line_t       merged;

    always_comb begin
        dmem_in       = dmem_req_i;
        dmem_in.write = dmem_write_i;   // port strobe sets the op
    end

    req_hold #(.req_t(imem_req_t)) i_imem_hold (
        .clk, .rst,
        .valid_i   (imem_read_i),
        .req_i     (imem_req_i),
        .done_i    (imem_done),
        .pending_o (imem_pending),
        .req_o     (imem_held)
    );

    req_hold #(.req_t(dmem_req_t)) i_dmem_hold (
        .clk, .rst,
        .valid_i   (dmem_read_i || dmem_write_i),
        .req_i     (dmem_in),
        .done_i    (dmem_done),
        .pending_o (dmem_pending),
        .req_o     (dmem_held)
    );

    // line address of the chosen client
    assign line_addr = sel_dmem ? {dmem_held.addr[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}}
                                : {imem_held.addr[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

    always_ff @(posedge clk) begin
        if (line_read && line_done) begin
            line_q <= rd_line;
        end
    end

    word_lane i_word_lane (
        .imem_addr_i (imem_held.addr),
        .line_i      (line_q),
        .req_i       (dmem_held),
        .imem_word_o (imem_rdata_o),
        .dmem_word_o (dmem_rdata_o),
        .merged_o    (merged)
    );

    mem_ctrl i_mem_ctrl (
        .clk, .rst,
        .imem_pending_i (imem_pending),
        .dmem_pending_i (dmem_pending),
        .dmem_write_i   (dmem_held.write),
        .line_done_i    (line_done),
        .line_read_o    (line_read),
        .line_write_o   (line_write),
        .sel_dmem_o     (sel_dmem),
        .imem_done_o    (imem_done),
        .dmem_done_o    (dmem_done)
    );

    burst_adaptor i_burst_adaptor (
        .clk, .rst,
        .line_read_i  (line_read),
        .line_write_i (line_write),
        .addr_i       (line_addr),
        .line_i       (merged),
        .line_o       (rd_line),
        .line_done_o  (line_done),
        .bmem_o       (bmem_o),
        .bmem_i       (bmem_i)
    );

    assign imem_resp_o = imem_done;
    assign dmem_resp_o = dmem_done;

endmodule : mem_hier

`default_nettype wire

//--- logic/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // line and beat geometry
    localparam int LINE_BITS   = 256;
    localparam int BEAT_BITS   = 64;
    localparam int BEATS       = LINE_BITS / BEAT_BITS;  // 4 beats per line
    localparam int CNT_BITS    = $clog2(BEATS);
    localparam int OFFSET_BITS = 5;                      // word index is addr[4:2]

    typedef logic [LINE_BITS-1:0] line_t;
    typedef logic [BEAT_BITS-1:0] beat_t;

    typedef struct packed {
        logic [31:0] addr;
    } imem_req_t;

    typedef struct packed {
        logic [31:0] addr;
        logic        write;
        logic [31:0] wdata;
        logic [3:0]  wmask;   // one bit per byte of wdata
    } dmem_req_t;

    // towards the burst memory
    typedef struct packed {
        logic [31:0] addr;    // line aligned
        logic        read;
        logic        write;
        beat_t       wdata;
    } bmem_out_t;

    typedef struct packed {
        beat_t rdata;
        logic  resp;
    } bmem_in_t;

endpackage : mem_pkg

`default_nettype wire

//--- logic/req_hold.sv
`timescale 1ns/10ps
`default_nettype none

module req_hold #(
    parameter type req_t = logic [31:0]
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic valid_i,
    input  wire req_t req_i,
    input  wire logic done_i,
    output logic      pending_o,
    output req_t      req_o
);

    logic pending_q;
    logic done_q;   // blocks capture right after a completion
    logic take;
    req_t req_q;

    assign take = valid_i && !pending_q && !done_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending_q <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            done_q <= done_i;
            if (done_i) begin
                pending_q <= 1'b0;   // valid_i ignored this cycle
            end else if (take) begin
                pending_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            req_q <= req_i;
        end
    end

    assign pending_o = pending_q;
    assign req_o     = req_q;

endmodule : req_hold

`default_nettype wire

//--- logic/word_lane.sv
`timescale 1ns/10ps
`default_nettype none

module word_lane (
    input  wire logic              [31:0] imem_addr_i,
    input  wire mem_pkg::line_t           line_i,
    input  wire mem_pkg::dmem_req_t       req_i,
    output logic                   [31:0] imem_word_o,
    output logic                   [31:0] dmem_word_o,
    output mem_pkg::line_t                merged_o
);

    import mem_pkg::*;

    logic [OFFSET_BITS-3:0] imem_idx;
    logic [OFFSET_BITS-3:0] dmem_idx;

    assign imem_idx = imem_addr_i[OFFSET_BITS-1:2];
    assign dmem_idx = req_i.addr[OFFSET_BITS-1:2];

    // word select for both clients
    assign imem_word_o = line_i[imem_idx*32 +: 32];
    assign dmem_word_o = line_i[dmem_idx*32 +: 32];

    // byte merge of the store word into the line
    always_comb begin
        merged_o = line_i;
        for (int b = 0; b < 4; b++) begin
            if (req_i.wmask[b]) begin
                merged_o[dmem_idx*32 + b*8 +: 8] = req_i.wdata[b*8 +: 8];
            end
        end
    end

endmodule : word_lane

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the mem_hier testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module mem_hier_tb \
    -f files.f \
    -o mem_hier_sim

./obj_dir/mem_hier_sim

//--- test/burst_mem_model.sv
`timescale 1ns/10ps
`default_nettype none

module burst_mem_model (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire mem_pkg::bmem_out_t req_i,
    output mem_pkg::bmem_in_t       rsp_o
);

    import mem_pkg::*;

    localparam int IDLE_CYCLES = 3;   // quiet cycles before the first beat

    beat_t      mem [0:63];   // 16 lines of 4 beats
    logic       busy_q;
    logic [3:0] cnt_q;
    logic [1:0] beat;
    logic [5:0] idx;
    logic       resp;

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], ~a[15:0]};
    endfunction

    initial begin
        for (int i = 0; i < 64; i++) begin
            mem[i] = {fill_word(32'(i * 8 + 4)), fill_word(32'(i * 8))};
        end
    end

    assign resp = busy_q && (cnt_q >= 4'(IDLE_CYCLES - 1));
    assign beat = 2'(cnt_q - 4'(IDLE_CYCLES - 1));
    assign idx  = {req_i.addr[8:5], beat};

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (!busy_q) begin
            if (req_i.read || req_i.write) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end
        end else begin
            cnt_q <= cnt_q + 4'd1;
            if (cnt_q == 4'(IDLE_CYCLES + BEATS - 2)) begin
                busy_q <= 1'b0;   // last beat
            end
        end
    end

    always @(posedge clk) begin
        if (resp && req_i.write) begin
            mem[idx] <= req_i.wdata;
        end
    end

    always_comb begin
        rsp_o.rdata = mem[idx];
        rsp_o.resp  = resp;
    end

endmodule : burst_mem_model

`default_nettype wire

//--- test/mem_hier_assert.sv
`timescale 1ns/10ps
`default_nettype none

module mem_hier_assert (
    input wire logic               clk,
    input wire logic               rst,
    input wire mem_pkg::bmem_out_t bmem_out_i,
    input wire mem_pkg::bmem_in_t  bmem_in_i,
    input wire logic               imem_resp_i,
    input wire logic               dmem_resp_i
);

    import mem_pkg::*;

    logic [CNT_BITS-1:0] beats_q;
    logic                active;
    logic                last_beat;

    assign active    = bmem_out_i.read || bmem_out_i.write;
    assign last_beat = active && bmem_in_i.resp && (beats_q == CNT_BITS'(BEATS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            beats_q <= '0;
        end else if (active && bmem_in_i.resp) begin
            beats_q <= beats_q + CNT_BITS'(1);
        end
    end

    a_rw_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(bmem_out_i.read && bmem_out_i.write))
        else $error("bmem read and write high together");

    a_line_aligned: assert property (@(posedge clk) disable iff (rst)
        active |-> (bmem_out_i.addr[OFFSET_BITS-1:0] == '0))
        else $error("bmem address not line aligned");

    a_imem_resp_pulse: assert property (@(posedge clk) disable iff (rst)
        imem_resp_i |=> !imem_resp_i)
        else $error("imem resp longer than one cycle");

    a_dmem_resp_pulse: assert property (@(posedge clk) disable iff (rst)
        dmem_resp_i |=> !dmem_resp_i)
        else $error("dmem resp longer than one cycle");

    // burst request held until its fourth beat
    a_burst_stable: assert property (@(posedge clk) disable iff (rst)
        (active && !last_beat) |=> ($stable(bmem_out_i.addr) && $stable(bmem_out_i.read)
                                    && $stable(bmem_out_i.write)))
        else $error("bmem request changed inside a burst");

endmodule : mem_hier_assert

bind mem_hier mem_hier_assert i_mem_hier_assert (
    .clk         (clk),
    .rst         (rst),
    .bmem_out_i  (bmem_o),
    .bmem_in_i   (bmem_i),
    .imem_resp_i (imem_resp_o),
    .dmem_resp_i (dmem_resp_o)
);

`default_nettype wire

//--- test/mem_hier_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mem_hier_tb;

    import mem_pkg::*;

    localparam int RAND_OPS       = 60;
    localparam int OP_CYCLES      = 24;   // worst case read-modify-write with handshake
    localparam int NUM_OPS        = 8 + 2 + 2 + RAND_OPS;
    localparam int TIMEOUT_CYCLES = NUM_OPS * OP_CYCLES + 100;
    localparam int RESP_WAIT      = 40;

    logic        clk;
    logic        rst;
    logic        imem_read;
    imem_req_t   imem_req;
    logic [31:0] imem_rdata;
    logic        imem_resp;
    logic        dmem_read;
    logic        dmem_write;
    dmem_req_t   dmem_req;
    logic [31:0] dmem_rdata;
    logic        dmem_resp;
    bmem_out_t   bmem_req;
    bmem_in_t    bmem_rsp;

    logic [31:0] ref_mem [0:127];   // word view of the model contents
    string       test_name;
    int          cycles = 0;
    integer      seed;

    mem_hier i_mem_hier (
        .clk          (clk),
        .rst          (rst),
        .imem_read_i  (imem_read),
        .imem_req_i   (imem_req),
        .imem_rdata_o (imem_rdata),
        .imem_resp_o  (imem_resp),
        .dmem_read_i  (dmem_read),
        .dmem_write_i (dmem_write),
        .dmem_req_i   (dmem_req),
        .dmem_rdata_o (dmem_rdata),
        .dmem_resp_o  (dmem_resp),
        .bmem_o       (bmem_req),
        .bmem_i       (bmem_rsp)
    );

    burst_mem_model i_model (
        .clk   (clk),
        .rst   (rst),
        .req_i (bmem_req),
        .rsp_o (bmem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Test failures found");
            $fatal(1, "run did not finish within %0d cycles", TIMEOUT_CYCLES);
        end
    end

    function automatic logic [31:0] expected_fill(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], ~a[15:0]};
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdata,
                                                input logic [3:0] mask);
        logic [31:0] r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                r[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return r;
    endfunction

    function automatic line_t model_line(input logic [31:0] addr);
        line_t l;
        for (int b = 0; b < BEATS; b++) begin
            l[b*BEAT_BITS +: BEAT_BITS] = i_model.mem[{addr[8:5], 2'(b)}];
        end
        return l;
    endfunction

    function automatic line_t ref_line(input logic [31:0] addr);
        line_t l;
        for (int w = 0; w < 8; w++) begin
            l[w*32 +: 32] = ref_mem[{addr[8:5], 3'(w)}];
        end
        return l;
    endfunction

    task automatic fail_now(input string msg);
        $display("%s in test %s", msg, test_name);
        $display("Test failures found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s %s: expected %b, actual %b", test_name, what, exp, act);
            fail_now("wrong flag value");
        end
    endtask

    task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
            fail_now("wrong read data");
        end
    endtask

    task automatic check_line(input string what, input line_t exp, input line_t act);
        if (act !== exp) begin
            $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
            fail_now("wrong memory line");
        end
    endtask

    task automatic wait_resp(input logic dmem_port);
        int n;
        n = 0;
        while ((dmem_port ? dmem_resp : imem_resp) !== 1'b1) begin
            if (n == RESP_WAIT) begin
                fail_now("no resp from the DUT within the wait limit");
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic store_ref(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] mask);
        ref_mem[addr[8:2]] = merge_bytes(ref_mem[addr[8:2]], wdata, mask);
    endtask

    task automatic imem_read_word(input logic [31:0] addr, output logic [31:0] data);
        @(negedge clk);
        imem_read     = 1'b1;
        imem_req.addr = addr;
        @(negedge clk);
        wait_resp(1'b0);
        data = imem_rdata;
        @(negedge clk);
        imem_read = 1'b0;   // the cycle after resp
    endtask

    task automatic dmem_access(input logic [31:0] addr, input logic write,
                               input logic [31:0] wdata, input logic [3:0] mask,
                               output logic [31:0] data);
        @(negedge clk);
        dmem_read      = !write;
        dmem_write     = write;
        dmem_req.addr  = addr;
        dmem_req.wdata = wdata;
        dmem_req.wmask = mask;
        @(negedge clk);
        wait_resp(1'b1);
        data = dmem_rdata;
        @(negedge clk);
        dmem_read  = 1'b0;
        dmem_write = 1'b0;
        if (write) begin
            store_ref(addr, wdata, mask);
        end
    endtask

    task automatic check_quiet();
        check_flag("bmem read", 1'b0, bmem_req.read);
        check_flag("bmem write", 1'b0, bmem_req.write);
        check_flag("imem resp", 1'b0, imem_resp);
        check_flag("dmem resp", 1'b0, dmem_resp);
    endtask

    task automatic test_reset();
        test_name = "reset";
        rst = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_quiet();
        end
        rst = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_quiet();
        end
    endtask

    task automatic test_imem_line();
        logic [31:0] addr;
        logic [31:0] data;
        test_name = "imem_line";
        for (int w = 0; w < 8; w++) begin
            addr = 32'h0000_0040 + 32'(w * 4);
            imem_read_word(addr, data);
            check_word("imem word", ref_mem[addr[8:2]], data);
        end
    endtask

    task automatic test_partial_write();
        logic [31:0] addr;
        logic [31:0] data;
        test_name = "partial_write";
        addr = 32'h0000_0088;
        dmem_access(addr, 1'b1, 32'ha5c3_0f96, 4'b0110, data);
        dmem_access(addr, 1'b0, 32'h0, 4'b0000, data);
        check_word("merged word", ref_mem[addr[8:2]], data);
        check_line("line after store", ref_line(addr), model_line(addr));
    endtask

    task automatic test_priority();
        logic [31:0] iaddr;
        logic [31:0] daddr;
        logic        imem_seen;
        logic        dmem_seen;
        int          n;
        test_name = "priority";
        iaddr     = 32'h0000_0104;
        daddr     = 32'h0000_0034;
        imem_seen = 1'b0;
        dmem_seen = 1'b0;
        n         = 0;
        @(negedge clk);
        imem_read      = 1'b1;
        imem_req.addr  = iaddr;
        dmem_read      = 1'b1;
        dmem_req.addr  = daddr;
        dmem_req.wmask = 4'b0000;
        while (!imem_seen) begin
            @(negedge clk);
            n++;
            if (dmem_seen) begin
                dmem_read = 1'b0;
            end
            if (dmem_resp) begin
                dmem_seen = 1'b1;
                check_word("dmem word", ref_mem[daddr[8:2]], dmem_rdata);
            end
            if (imem_resp) begin
                check_flag("dmem resp first", 1'b1, dmem_seen);
                imem_seen = 1'b1;
                check_word("imem word", ref_mem[iaddr[8:2]], imem_rdata);
            end
            if (n == 2 * RESP_WAIT) begin
                fail_now("both requests not answered within the wait limit");
            end
        end
        @(negedge clk);
        imem_read = 1'b0;
    endtask

    task automatic test_random();
        logic [31:0] r;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] data;
        test_name = "random";
        for (int i = 0; i < RAND_OPS; i++) begin
            r    = $random(seed);
            addr = {25'd0, r[6:2], 2'b00};   // four line window
            case (r[9:8])
                2'd0: begin
                    imem_read_word(addr, data);
                    check_word("imem word", ref_mem[addr[8:2]], data);
                end
                2'd1: begin
                    dmem_access(addr, 1'b0, 32'h0, 4'b0000, data);
                    check_word("dmem word", ref_mem[addr[8:2]], data);
                end
                default: begin
                    wdata = $random(seed);
                    dmem_access(addr, 1'b1, wdata, r[13:10], data);
                end
            endcase
        end
        for (int l = 0; l < 4; l++) begin
            check_line("window line", ref_line(32'(l * 32)), model_line(32'(l * 32)));
        end
    endtask

    initial begin
        seed       = 32'hd882_66bf;
        rst        = 1'b1;
        imem_read  = 1'b0;
        imem_req   = '0;
        dmem_read  = 1'b0;
        dmem_write = 1'b0;
        dmem_req   = '0;
        for (int i = 0; i < 128; i++) begin
            ref_mem[i] = expected_fill(32'(i * 4));
        end
        test_reset();
        test_imem_line();
        test_partial_write();
        test_priority();
        test_random();
        @(negedge clk);
        $display("All tests passed!");
        $finish;
    end

endmodule : mem_hier_tb

`default_nettype wire
